// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = cacheline_stream_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
PASS_TEXT  = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
source/cu_pkg.sv
source/mixed_width_ram.sv
source/cacheline_half_router.sv
source/cu_cacheline_stream.sv
source/cacheline_stream_top.sv
test/cacheline_stream_asserts.sv
test/cacheline_stream_tb.sv

// ==== source/cacheline_half_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheline_half_router import cu_pkg::*; (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled,
	input  logic                                rsp_valid,
	input  logic                                rsp_half,
	input  vertex_struct_type                   rsp_struct,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] rsp_offset,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] rsp_limit,
	input  logic [0:HALF_LINE_BITS-1]           rsp_data,
	output logic                                lane_valid_0,
	output vertex_struct_type                   lane_struct_0,
	output logic [CACHELINE_INT_COUNTER_BITS:0] lane_offset_0,
	output logic [CACHELINE_INT_COUNTER_BITS:0] lane_limit_0,
	output logic [0:HALF_LINE_BITS-1]           lane_data_0,
	output logic                                lane_valid_1,
	output vertex_struct_type                   lane_struct_1,
	output logic [CACHELINE_INT_COUNTER_BITS:0] lane_offset_1,
	output logic [CACHELINE_INT_COUNTER_BITS:0] lane_limit_1,
	output logic [0:HALF_LINE_BITS-1]           lane_data_1
);

	logic take_0;
	logic take_1;

	// Half 0 holds words 0 to 15 and goes to lane 0
	assign take_0 = enabled && rsp_valid && !rsp_half;
	assign take_1 = enabled && rsp_valid && rsp_half;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lane_valid_0 <= 1'b0;
			lane_valid_1 <= 1'b0;
		end else begin
			lane_valid_0 <= take_0; // Single cycle pulse per beat
			lane_valid_1 <= take_1;
		end
	end

	always_ff @(posedge clock) begin
		if (take_0) begin
			lane_struct_0 <= rsp_struct;
			lane_offset_0 <= rsp_offset;
			lane_limit_0  <= rsp_limit;
			lane_data_0   <= rsp_data;
		end
		if (take_1) begin
			lane_struct_1 <= rsp_struct;
			lane_offset_1 <= rsp_offset;
			lane_limit_1  <= rsp_limit;
			lane_data_1   <= rsp_data;
		end
	end

endmodule

`default_nettype wire

// ==== source/cacheline_stream_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheline_stream_top import cu_pkg::*; #(
	parameter vertex_struct_type STRUCT_0 = STRUCT_IN_DEGREE,
	parameter vertex_struct_type STRUCT_1 = STRUCT_OUT_DEGREE
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled,
	input  logic                                shift_0,
	input  logic                                shift_1,
	input  logic                                rsp_valid,
	input  logic                                rsp_half,
	input  vertex_struct_type                   rsp_struct,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] rsp_offset,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] rsp_limit,
	input  logic [0:HALF_LINE_BITS-1]           rsp_data,
	output logic [0:VERTEX_SIZE_BITS-1]         vertex_0,
	output logic                                valid_0,
	output logic                                pending_0,
	output logic [0:VERTEX_SIZE_BITS-1]         vertex_1,
	output logic                                valid_1,
	output logic                                pending_1
);

	logic                                lane_valid_0;
	vertex_struct_type                   lane_struct_0;
	logic [CACHELINE_INT_COUNTER_BITS:0] lane_offset_0;
	logic [CACHELINE_INT_COUNTER_BITS:0] lane_limit_0;
	logic [0:HALF_LINE_BITS-1]           lane_data_0;
	logic                                lane_valid_1;
	vertex_struct_type                   lane_struct_1;
	logic [CACHELINE_INT_COUNTER_BITS:0] lane_offset_1;
	logic [CACHELINE_INT_COUNTER_BITS:0] lane_limit_1;
	logic [0:HALF_LINE_BITS-1]           lane_data_1;

	cacheline_half_router router0 (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.rsp_valid    (rsp_valid),
		.rsp_half     (rsp_half),
		.rsp_struct   (rsp_struct),
		.rsp_offset   (rsp_offset),
		.rsp_limit    (rsp_limit),
		.rsp_data     (rsp_data),
		.lane_valid_0 (lane_valid_0),
		.lane_struct_0(lane_struct_0),
		.lane_offset_0(lane_offset_0),
		.lane_limit_0 (lane_limit_0),
		.lane_data_0  (lane_data_0),
		.lane_valid_1 (lane_valid_1),
		.lane_struct_1(lane_struct_1),
		.lane_offset_1(lane_offset_1),
		.lane_limit_1 (lane_limit_1),
		.lane_data_1  (lane_data_1)
	);

	// Both units see both lanes and keep only their own field
	cu_cacheline_stream #(
		.STRUCT_ID(STRUCT_0)
	) stream0 (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.start_shift  (shift_0),
		.lane_valid_0 (lane_valid_0),
		.lane_struct_0(lane_struct_0),
		.lane_offset_0(lane_offset_0),
		.lane_limit_0 (lane_limit_0),
		.lane_data_0  (lane_data_0),
		.lane_valid_1 (lane_valid_1),
		.lane_struct_1(lane_struct_1),
		.lane_offset_1(lane_offset_1),
		.lane_limit_1 (lane_limit_1),
		.lane_data_1  (lane_data_1),
		.vertex       (vertex_0),
		.pending      (pending_0),
		.valid        (valid_0)
	);

	cu_cacheline_stream #(
		.STRUCT_ID(STRUCT_1)
	) stream1 (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.start_shift  (shift_1),
		.lane_valid_0 (lane_valid_0),
		.lane_struct_0(lane_struct_0),
		.lane_offset_0(lane_offset_0),
		.lane_limit_0 (lane_limit_0),
		.lane_data_0  (lane_data_0),
		.lane_valid_1 (lane_valid_1),
		.lane_struct_1(lane_struct_1),
		.lane_offset_1(lane_offset_1),
		.lane_limit_1 (lane_limit_1),
		.lane_data_1  (lane_data_1),
		.vertex       (vertex_1),
		.pending      (pending_1),
		.valid        (valid_1)
	);

endmodule

`default_nettype wire

// ==== source/cu_cacheline_stream.sv ====
`timescale 1ns/10ps
`default_nettype none

module cu_cacheline_stream import cu_pkg::*; #(
	parameter vertex_struct_type STRUCT_ID = STRUCT_IN_DEGREE
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled,
	input  logic                                start_shift,
	input  logic                                lane_valid_0,
	input  vertex_struct_type                   lane_struct_0,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] lane_offset_0,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] lane_limit_0,
	input  logic [0:HALF_LINE_BITS-1]           lane_data_0,
	input  logic                                lane_valid_1,
	input  vertex_struct_type                   lane_struct_1,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] lane_offset_1,
	input  logic [CACHELINE_INT_COUNTER_BITS:0] lane_limit_1,
	input  logic [0:HALF_LINE_BITS-1]           lane_data_1,
	output logic [0:VERTEX_SIZE_BITS-1]         vertex,
	output logic                                pending,
	output logic                                valid
);

	logic match_0;
	logic match_1;
	logic we;
	logic wr_half;
	logic [0:HALF_LINE_BITS-1]           wr_data;
	logic [CACHELINE_INT_COUNTER_BITS:0] wr_offset;
	logic [CACHELINE_INT_COUNTER_BITS:0] wr_limit;

	logic [CACHELINE_INT_COUNTER_BITS:0] shift_counter;
	logic [CACHELINE_INT_COUNTER_BITS:0] shift_limit;
	logic [0:VERTEX_SIZE_BITS-1]         ram_word;
	logic                                shift_issue;

	// ************************************************************************
	// Lane selection, lane 0 wins when both carry this field
	// ************************************************************************

	assign match_0 = lane_valid_0 && (lane_struct_0 == STRUCT_ID);
	assign match_1 = lane_valid_1 && (lane_struct_1 == STRUCT_ID);
	assign we      = match_0 || match_1;
	assign wr_half = !match_0; // RAM entry follows the lane, which follows the half

	always_comb begin
		if (match_0) begin
			wr_data   = lane_data_0;
			wr_offset = lane_offset_0;
			wr_limit  = lane_limit_0;
		end else begin
			wr_data   = lane_data_1;
			wr_offset = lane_offset_1;
			wr_limit  = lane_limit_1;
		end
	end

	// ************************************************************************
	// Word counter and pending state
	// ************************************************************************

	// A reload takes the cycle, the read restarts from the new offset after it
	assign shift_issue = enabled && start_shift && !we && (shift_counter < shift_limit);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			shift_counter <= '0;
			shift_limit   <= '0;
			pending       <= 1'b0;
			valid         <= 1'b0;
		end else if (!enabled) begin
			shift_counter <= '0;
			shift_limit   <= '0;
			pending       <= 1'b0;
			valid         <= 1'b0;
		end else begin
			valid <= shift_issue; // Lines up with the registered RAM read
			if (we) begin
				shift_counter <= wr_offset;
				shift_limit   <= wr_limit;
				pending       <= 1'b1;
			end else if (shift_issue) begin
				shift_counter <= shift_counter + 1'b1;
			end else if (start_shift) begin
				pending <= 1'b0; // Window exhausted
			end
		end
	end

	mixed_width_ram #(
		.WORDS(2),
		.WW   (HALF_LINE_BITS),
		.RW   (VERTEX_SIZE_BITS)
	) cacheline_ram (
		.clock   (clock),
		.we      (we),
		.wr_addr (wr_half),
		.data_in (wr_data),
		.rd_addr (shift_counter[CACHELINE_INT_COUNTER_BITS-1:0]),
		.data_out(ram_word)
	);

	assign vertex = swap_endianness_word(ram_word);

endmodule

`default_nettype wire

// ==== source/cu_pkg.sv ====
`default_nettype none

package cu_pkg;

	// ************************************************************************
	// Cacheline geometry
	// ************************************************************************

	parameter int CACHELINE_SIZE_BITS = 1024;
	parameter int HALF_LINE_BITS      = CACHELINE_SIZE_BITS / 2; // One response beat
	parameter int VERTEX_SIZE_BITS    = 32;

	// Indexes the 32 words of a line, counters carry one more bit so 32 fits
	parameter int CACHELINE_INT_COUNTER_BITS = 5;

	// ************************************************************************
	// Vertex array field tags
	// ************************************************************************

	typedef enum logic [1:0] {
		STRUCT_NONE,
		STRUCT_IN_DEGREE,
		STRUCT_OUT_DEGREE,
		STRUCT_EDGES_IDX
	} vertex_struct_type;

	// Memory words come in little-endian byte order, bit 0 is the MSB here
	function automatic logic [0:VERTEX_SIZE_BITS-1] swap_endianness_word(
		input logic [0:VERTEX_SIZE_BITS-1] word
	);
		logic [0:VERTEX_SIZE_BITS-1] swapped;
		swapped = {word[24:31], word[16:23], word[8:15], word[0:7]};
		return swapped;
	endfunction

endpackage

`default_nettype wire

// ==== source/mixed_width_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module mixed_width_ram #(
	parameter int WORDS = 2,
	parameter int WW    = 512,
	parameter int RW    = 32
) (
	input  logic                               clock,
	input  logic                               we,
	input  logic [$clog2(WORDS)-1:0]           wr_addr,
	input  logic [0:WW-1]                      data_in,
	input  logic [$clog2(WORDS*(WW/RW))-1:0]   rd_addr,
	output logic [0:RW-1]                      data_out
);

	localparam int RATIO    = WW / RW;           // Narrow words per wide entry
	localparam int POS_BITS = $clog2(RATIO);
	localparam int RD_AW    = $clog2(WORDS * RATIO);

	logic [0:WW-1] mem [0:WORDS-1];

	logic [$clog2(WORDS)-1:0] rd_entry;
	logic [POS_BITS-1:0]      rd_pos;

	// Upper read address bits pick the entry, lower ones the narrow word in it
	assign rd_entry = rd_addr[RD_AW-1:POS_BITS];
	assign rd_pos   = rd_addr[POS_BITS-1:0];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr_addr] <= data_in;
		end
	end

	// Word 0 sits at bit 0 of entry 0, so the ascending part select walks the entry
	always_ff @(posedge clock) begin
		data_out <= mem[rd_entry][int'(rd_pos) * RW +: RW];
	end

endmodule

`default_nettype wire

// ==== test/cacheline_stream_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheline_stream_asserts (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input logic load,
	input logic pending,
	input logic valid,
	input logic lane_valid_0,
	input logic lane_valid_1
);

	// ************************************************************************
	// Stream unit properties
	// ************************************************************************

	valid_needs_enable: assert property (@(posedge clock) disable iff (!rstn)
		valid |-> $past(enabled))
		else $error("valid rose although enabled was low in the previous cycle");

	// A load in the idle cycle may start a word two cycles on, so it is excluded
	no_valid_when_idle: assert property (@(posedge clock) disable iff (!rstn)
		$past(!pending && !load, 2) |-> !valid)
		else $error("valid rose two cycles after an idle cycle without a load");

	one_lane_per_beat: assert property (@(posedge clock) disable iff (!rstn)
		!(lane_valid_0 && lane_valid_1))
		else $error("both lanes pulsed in the same cycle");

endmodule

bind cu_cacheline_stream cacheline_stream_asserts asserts0 (
	.clock       (clock),
	.rstn        (rstn),
	.enabled     (enabled),
	.load        (we),
	.pending     (pending),
	.valid       (valid),
	.lane_valid_0(lane_valid_0),
	.lane_valid_1(lane_valid_1)
);

`default_nettype wire

// ==== test/cacheline_stream_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheline_stream_tb import cu_pkg::*; ();

	localparam int PENDING_TIMEOUT = 20;
	localparam int STREAM_TIMEOUT  = 400;
	localparam int DROP_NONE       = 0;
	localparam int DROP_ENABLE     = 1;
	localparam int DROP_RESET      = 2;

	typedef struct {
		string             name;
		vertex_struct_type tag;
		int                offset;
		int                limit;
		bit                gaps;       // Shift toggled at random
		int                drop_mode;
		int                drop_after; // Words taken before the drop
	} test_case_t;

	logic                                clock;
	logic                                rstn;
	logic                                enabled;
	logic [1:0]                          shift_bus;
	logic                                rsp_valid;
	logic                                rsp_half;
	vertex_struct_type                   rsp_struct;
	logic [CACHELINE_INT_COUNTER_BITS:0] rsp_offset;
	logic [CACHELINE_INT_COUNTER_BITS:0] rsp_limit;
	logic [0:HALF_LINE_BITS-1]           rsp_data;
	logic [0:VERTEX_SIZE_BITS-1]         vertex_0;
	logic [0:VERTEX_SIZE_BITS-1]         vertex_1;
	logic                                valid_0;
	logic                                valid_1;
	logic                                pending_0;
	logic                                pending_1;

	logic [1:0]  valid_bus;
	logic [1:0]  pending_bus;
	logic [31:0] vertex_bus [0:1];
	logic [31:0] line_words [0:31];
	test_case_t  cases [$];
	integer      seed;
	int          failures;

	assign valid_bus     = {valid_1, valid_0};
	assign pending_bus   = {pending_1, pending_0};
	assign vertex_bus[0] = vertex_0;
	assign vertex_bus[1] = vertex_1;

	cacheline_stream_top dut0 (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.shift_0   (shift_bus[0]),
		.shift_1   (shift_bus[1]),
		.rsp_valid (rsp_valid),
		.rsp_half  (rsp_half),
		.rsp_struct(rsp_struct),
		.rsp_offset(rsp_offset),
		.rsp_limit (rsp_limit),
		.rsp_data  (rsp_data),
		.vertex_0  (vertex_0),
		.valid_0   (valid_0),
		.pending_0 (pending_0),
		.vertex_1  (vertex_1),
		.valid_1   (valid_1),
		.pending_1 (pending_1)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ************************************************************************
	// Checking and reporting
	// ************************************************************************

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			failures++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		abort_run();
	endtask

	task automatic expect_outputs_idle(input string name);
		check_value({name, " valid_0"}, 32'd0, 32'(valid_0));
		check_value({name, " valid_1"}, 32'd0, 32'(valid_1));
		check_value({name, " pending_0"}, 32'd0, 32'(pending_0));
		check_value({name, " pending_1"}, 32'd0, 32'(pending_1));
	endtask

	// The stream presents word w of the line with its four bytes reversed
	function automatic logic [31:0] model_vertex(input int index);
		logic [31:0] word;
		word = line_words[index];
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	// ************************************************************************
	// Stimulus
	// ************************************************************************

	task automatic add_case(input string name, input vertex_struct_type tag,
		input int offset, input int limit, input bit gaps, input int drop_mode,
		input int drop_after);
		test_case_t c;
		c.name       = name;
		c.tag        = tag;
		c.offset     = offset;
		c.limit      = limit;
		c.gaps       = gaps;
		c.drop_mode  = drop_mode;
		c.drop_after = drop_after;
		cases.push_back(c);
	endtask

	task automatic send_line(input test_case_t c);
		logic [0:HALF_LINE_BITS-1] data;
		for (int w = 0; w < 32; w++) begin
			line_words[w] = $random(seed);
		end
		for (int h = 0; h < 2; h++) begin
			for (int p = 0; p < 16; p++) begin
				data[p*32 +: 32] = line_words[h*16 + p]; // Word 0 at bit 0
			end
			@(negedge clock);
			rsp_valid  = 1'b1;
			rsp_half   = h[0];
			rsp_struct = c.tag;
			rsp_offset = 6'(c.offset);
			rsp_limit  = 6'(c.limit);
			rsp_data   = data;
		end
		@(negedge clock);
		rsp_valid = 1'b0;
	endtask

	task automatic wait_pending(input test_case_t c, input logic sel);
		int cycles;
		cycles = 0;
		while (!pending_bus[sel]) begin
			@(negedge clock);
			check_value({c.name, " other pending"}, 32'd0, 32'(pending_bus[!sel]));
			cycles++;
			if (cycles > PENDING_TIMEOUT) begin
				report_timeout("pending to rise after the line was sent");
			end
		end
	endtask

	task automatic drop_stream(input test_case_t c, input logic sel);
		// Shift stays high so only the drop itself can stop the words
		if (c.drop_mode == DROP_ENABLE) begin
			enabled = 1'b0;
			@(negedge clock);
			check_value({c.name, " pending"}, 32'd0, 32'(pending_bus[sel]));
			check_value({c.name, " valid"}, 32'd0, 32'(valid_bus[sel]));
			enabled = 1'b1;
		end else begin
			rstn = 1'b0;
			repeat (3) begin
				@(negedge clock);
				expect_outputs_idle(c.name);
			end
			rstn = 1'b1;
		end
	endtask

	task automatic stream_words(input test_case_t c, input logic sel);
		int          count;
		int          cycles;
		logic        done;
		logic [31:0] rnd;
		count     = 0;
		cycles    = 0;
		done      = 1'b0;
		shift_bus = 2'b11; // The other unit shifts as well and has to stay silent
		while (!done) begin
			@(negedge clock);
			check_value({c.name, " other valid"}, 32'd0, 32'(valid_bus[!sel]));
			check_value({c.name, " other pending"}, 32'd0, 32'(pending_bus[!sel]));
			if (valid_bus[sel]) begin
				if (c.offset + count >= c.limit) begin
					check_value({c.name, " word count"}, 32'(c.limit - c.offset),
						32'(count + 1));
				end else begin
					check_value($sformatf("%s word %0d", c.name, c.offset + count),
						model_vertex(c.offset + count), vertex_bus[sel]);
				end
				count++;
			end
			if (c.drop_mode != DROP_NONE && count == c.drop_after) begin
				drop_stream(c, sel);
				done = 1'b1;
			end else if (!pending_bus[sel]) begin
				done = 1'b1; // Window exhausted
			end else begin
				cycles++;
				if (cycles > STREAM_TIMEOUT) begin
					report_timeout("pending to fall at the end of the word stream");
				end
				if (c.gaps) begin
					rnd            = $random(seed);
					shift_bus[sel] = rnd[0];
				end
			end
		end
		shift_bus = 2'b00;
		if (c.drop_mode == DROP_NONE) begin
			check_value({c.name, " word count"}, 32'(c.limit - c.offset), 32'(count));
		end
	endtask

	task automatic run_case(input test_case_t c);
		logic sel;
		send_line(c);
		if (c.tag != STRUCT_IN_DEGREE && c.tag != STRUCT_OUT_DEGREE) begin
			// Neither unit owns this field so both stay idle past the load latency
			shift_bus = 2'b11;
			repeat (6) begin
				@(negedge clock);
				expect_outputs_idle(c.name);
			end
			shift_bus = 2'b00;
		end else begin
			sel = (c.tag == STRUCT_OUT_DEGREE);
			wait_pending(c, sel);
			stream_words(c, sel);
		end
	endtask

	initial begin
		rstn       = 1'b0;
		enabled    = 1'b0;
		shift_bus  = 2'b00;
		rsp_valid  = 1'b0;
		rsp_half   = 1'b0;
		rsp_struct = STRUCT_NONE;
		rsp_offset = '0;
		rsp_limit  = '0;
		rsp_data   = '0;
		seed       = 7091;
		failures   = 0;
		add_case("full_line_in",    STRUCT_IN_DEGREE,  0, 32, 1'b0, DROP_NONE,   0);
		add_case("full_line_out",   STRUCT_OUT_DEGREE, 0, 32, 1'b0, DROP_NONE,   0);
		add_case("partial_window",  STRUCT_IN_DEGREE,  5, 21, 1'b0, DROP_NONE,   0);
		add_case("empty_window",    STRUCT_OUT_DEGREE, 9,  9, 1'b0, DROP_NONE,   0);
		add_case("edges_ignored",   STRUCT_EDGES_IDX,  0, 32, 1'b0, DROP_NONE,   0);
		add_case("gaps_full_line",  STRUCT_IN_DEGREE,  0, 32, 1'b1, DROP_NONE,   0);
		add_case("gaps_window",     STRUCT_OUT_DEGREE, 3, 30, 1'b1, DROP_NONE,   0);
		add_case("enable_drop",     STRUCT_IN_DEGREE,  0, 32, 1'b0, DROP_ENABLE, 10);
		add_case("reset_drop",      STRUCT_OUT_DEGREE, 4, 28, 1'b0, DROP_RESET,  7);
		add_case("after_drops",     STRUCT_IN_DEGREE,  2, 18, 1'b1, DROP_NONE,   0);
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		expect_outputs_idle("power_on_reset");
		enabled = 1'b1;
		foreach (cases[i]) begin
			run_case(cases[i]);
		end
		if (failures == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire
